// File: hw/trace_pkg.sv
/*
 * Widths, field encodings and reset values for the retirement trace unit.
 * Shared by the RTL blocks and the testbench checker.
 */
package trace_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  // Compressed instruction half
  localparam int unsigned INSN_C_W   = 16;
  localparam int unsigned ORDER_W    = 64;
  localparam int unsigned PRIV_W     = 2;
  localparam int unsigned DTYPE_W    = 2;
  localparam int unsigned MASK_W     = 4;
  localparam int unsigned PC_MUX_W   = 3;
  localparam int unsigned EXC_MUX_W  = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Machine mode, also the mode after reset
  localparam logic [PRIV_W-1:0] PRIV_M = 2'd3;

  // Access size codes from the load/store unit
  localparam logic [DTYPE_W-1:0] DTYPE_WORD = 2'd0;
  localparam logic [DTYPE_W-1:0] DTYPE_HALF = 2'd1;
  localparam logic [DTYPE_W-1:0] DTYPE_BYTE = 2'd2;

  // Byte masks per access size
  localparam logic [MASK_W-1:0] MASK_WORD = 4'b1111;
  localparam logic [MASK_W-1:0] MASK_HALF = 4'b0011;
  localparam logic [MASK_W-1:0] MASK_BYTE = 4'b0001;

  // Next-PC selector value for an exception redirect
  localparam logic [PC_MUX_W-1:0] PC_SEL_EXC = 3'd2;

  // Exception-PC selector values that enter a trap handler
  localparam logic [EXC_MUX_W-1:0] EXC_PC_EXC = 2'd0;
  localparam logic [EXC_MUX_W-1:0] EXC_PC_IRQ = 2'd1;

endpackage

// File: hw/trace_insn_capture.sv
/*
 * Tracks the open instruction between decode and retirement, latches its
 * source operands and formats the trace instruction word.
 */
module trace_insn_capture (
  input  logic                           clk,
  input  logic                           rst_ni,
  input  logic                           instr_new_i,
  input  logic                           instr_ret_i,
  input  logic [trace_pkg::XLEN-1:0]     instr_rdata_i,
  input  logic [trace_pkg::INSN_C_W-1:0] instr_rdata_c_i,
  input  logic                           instr_is_compressed_i,
  input  logic [trace_pkg::XLEN-1:0]     rs1_data_i,
  input  logic [trace_pkg::XLEN-1:0]     rs2_data_i,
  output logic                           insn_open_o,
  output logic [trace_pkg::XLEN-1:0]     insn_o,
  output logic [trace_pkg::XLEN-1:0]     rs1_data_o,
  output logic [trace_pkg::XLEN-1:0]     rs2_data_o
);

  import trace_pkg::*;

  logic            open_q;
  logic [XLEN-1:0] rs1_data_q;
  logic [XLEN-1:0] rs2_data_q;

  // Open from the decode strobe until retirement
  assign insn_open_o = instr_new_i | open_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q <= 1'b0;
    end else if (instr_ret_i) begin
      open_q <= 1'b0;
    end else begin
      open_q <= insn_open_o;
    end
  end

  // Operands are sampled when the instruction enters decode
  // The register file may change underneath before retirement
  always_comb begin
    if (instr_new_i) begin
      rs1_data_o = rs1_data_i;
      rs2_data_o = rs2_data_i;
    end else begin
      rs1_data_o = rs1_data_q;
      rs2_data_o = rs2_data_q;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_data_q <= '0;
      rs2_data_q <= '0;
    end else begin
      rs1_data_q <= rs1_data_o;
      rs2_data_q <= rs2_data_o;
    end
  end

  // Compressed encodings are reported as the raw 16-bit half
  always_comb begin
    if (instr_is_compressed_i) begin
      insn_o = {{(XLEN - INSN_C_W){1'b0}}, instr_rdata_c_i};
    end else begin
      insn_o = instr_rdata_i;
    end
  end

endmodule

// File: hw/trace_rd_capture.sv
/*
 * Holds the destination register address and write data of the open
 * instruction until it retires.
 */
module trace_rd_capture (
  input  logic                             clk,
  input  logic                             rst_ni,
  input  logic                             insn_open_i,
  input  logic                             rd_we_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       rd_wdata_i,
  output logic [trace_pkg::REG_ADDR_W-1:0] rd_addr_o,
  output logic [trace_pkg::XLEN-1:0]       rd_wdata_o
);

  import trace_pkg::*;

  logic [REG_ADDR_W-1:0] rd_addr_q;
  logic [XLEN-1:0]       rd_wdata_q;

  always_comb begin
    if (insn_open_i) begin
      if (!rd_we_i) begin
        // No write back at all
        rd_addr_o  = '0;
        rd_wdata_o = '0;
      end else begin
        rd_addr_o = rd_addr_i;
        // x0 always reads zero
        if (rd_addr_i == '0) begin
          rd_wdata_o = '0;
        end else begin
          rd_wdata_o = rd_wdata_i;
        end
      end
    end else begin
      rd_addr_o  = rd_addr_q;
      rd_wdata_o = rd_wdata_q;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_addr_q  <= '0;
      rd_wdata_q <= '0;
    end else begin
      rd_addr_q  <= rd_addr_o;
      rd_wdata_q <= rd_wdata_o;
    end
  end

endmodule

// File: hw/trace_mem_capture.sv
/*
 * Memory side of the trace record. Decodes the byte masks from the access
 * size and keeps the address and data of the last completed access.
 */
module trace_mem_capture (
  input  logic                          clk,
  input  logic                          rst_ni,
  input  logic                          insn_open_i,
  input  logic                          lsu_data_valid_i,
  input  logic [trace_pkg::DTYPE_W-1:0] data_type_i,
  input  logic                          data_we_i,
  input  logic [trace_pkg::XLEN-1:0]    mem_addr_i,
  input  logic [trace_pkg::XLEN-1:0]    mem_rdata_i,
  input  logic [trace_pkg::XLEN-1:0]    mem_wdata_i,
  output logic [trace_pkg::XLEN-1:0]    mem_addr_o,
  output logic [trace_pkg::XLEN-1:0]    mem_rdata_o,
  output logic [trace_pkg::XLEN-1:0]    mem_wdata_o,
  output logic [trace_pkg::MASK_W-1:0]  mem_rmask_o,
  output logic [trace_pkg::MASK_W-1:0]  mem_wmask_o
);

  import trace_pkg::*;

  logic [MASK_W-1:0] byte_mask;
  logic              capture;
  logic [XLEN-1:0]   mem_addr_q;
  logic [XLEN-1:0]   mem_rdata_q;
  logic [XLEN-1:0]   mem_wdata_q;

  // Byte enables from the access size
  always_comb begin
    unique case (data_type_i)
      DTYPE_WORD: byte_mask = MASK_WORD;
      DTYPE_HALF: byte_mask = MASK_HALF;
      DTYPE_BYTE: byte_mask = MASK_BYTE;
      default:    byte_mask = '0;
    endcase
  end

  assign mem_rmask_o = byte_mask;
  // Loads never report a write mask
  assign mem_wmask_o = data_we_i ? byte_mask : '0;

  assign capture = insn_open_i & lsu_data_valid_i;

  always_comb begin
    if (capture) begin
      mem_addr_o  = mem_addr_i;
      mem_rdata_o = mem_rdata_i;
      mem_wdata_o = mem_wdata_i;
    end else begin
      mem_addr_o  = mem_addr_q;
      mem_rdata_o = mem_rdata_q;
      mem_wdata_o = mem_wdata_q;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_addr_q  <= '0;
      mem_rdata_q <= '0;
      mem_wdata_q <= '0;
    end else begin
      mem_addr_q  <= mem_addr_o;
      mem_rdata_q <= mem_rdata_o;
      mem_wdata_q <= mem_wdata_o;
    end
  end

endmodule

// File: hw/trace_trap_tracker.sv
/*
 * Flags the first instruction that retires after the PC was redirected
 * into a trap handler.
 */
module trace_trap_tracker (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic                            insn_open_i,
  input  logic                            instr_ret_i,
  input  logic                            pc_set_i,
  input  logic [trace_pkg::PC_MUX_W-1:0]  pc_mux_i,
  input  logic [trace_pkg::EXC_MUX_W-1:0] exc_pc_mux_i,
  output logic                            intr_o
);

  import trace_pkg::*;

  logic trap_redirect;
  logic trap_entry_d;
  logic trap_entry_q;

  // Exception or interrupt entry through the exception PC mux
  assign trap_redirect = pc_set_i && (pc_mux_i == PC_SEL_EXC) &&
                         ((exc_pc_mux_i == EXC_PC_EXC) || (exc_pc_mux_i == EXC_PC_IRQ));

  always_comb begin
    trap_entry_d = trap_entry_q;
    if (trap_redirect) begin
      trap_entry_d = 1'b1;
    end else if (trap_entry_q && instr_ret_i) begin
      // Handler's first instruction is done
      trap_entry_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_entry_q <= 1'b0;
    end else begin
      trap_entry_q <= trap_entry_d;
    end
  end

  assign intr_o = trap_entry_q & insn_open_i;

endmodule

// File: hw/retire_tracer.sv
/*
 * Retirement trace unit. Watches the pipeline events and emits one
 * registered record per retired instruction, with a running order count.
 */
module retire_tracer (
  input  logic                             clk,
  input  logic                             rst_ni,
  // Pipeline events
  input  logic [trace_pkg::XLEN-1:0]       pc_id_i,
  input  logic [trace_pkg::XLEN-1:0]       pc_if_i,
  input  logic                             instr_new_i,
  input  logic                             instr_ret_i,
  input  logic                             illegal_insn_i,
  input  logic [trace_pkg::XLEN-1:0]       instr_rdata_i,
  input  logic [trace_pkg::INSN_C_W-1:0]   instr_rdata_c_i,
  input  logic                             instr_is_compressed_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [trace_pkg::XLEN-1:0]       rs2_data_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       rd_wdata_i,
  input  logic                             rd_we_i,
  input  logic                             lsu_data_valid_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_rdata_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_wdata_i,
  input  logic [trace_pkg::DTYPE_W-1:0]    data_type_i,
  input  logic                             data_we_i,
  input  logic                             pc_set_i,
  input  logic [trace_pkg::PC_MUX_W-1:0]   pc_mux_i,
  input  logic [trace_pkg::EXC_MUX_W-1:0]  exc_pc_mux_i,
  input  logic [trace_pkg::PRIV_W-1:0]     priv_mode_i,
  // Trace record
  output logic                             rvfi_valid_o,
  output logic [trace_pkg::ORDER_W-1:0]    rvfi_order_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_insn_o,
  output logic                             rvfi_trap_o,
  output logic                             rvfi_intr_o,
  output logic [trace_pkg::PRIV_W-1:0]     rvfi_mode_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] rvfi_rs1_addr_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] rvfi_rs2_addr_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_rs1_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_rs2_rdata_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] rvfi_rd_addr_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_rd_wdata_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_pc_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_pc_wdata_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_mem_addr_o,
  output logic [trace_pkg::MASK_W-1:0]     rvfi_mem_rmask_o,
  output logic [trace_pkg::MASK_W-1:0]     rvfi_mem_wmask_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_mem_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       rvfi_mem_wdata_o
);

  import trace_pkg::*;

  logic                  insn_open;
  logic [XLEN-1:0]       insn_word;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       rd_wdata;
  logic [XLEN-1:0]       mem_addr;
  logic [XLEN-1:0]       mem_rdata;
  logic [XLEN-1:0]       mem_wdata;
  logic [MASK_W-1:0]     mem_rmask;
  logic [MASK_W-1:0]     mem_wmask;
  logic                  intr;

  ////////////////////////////////////////////////////////////////////////////
  // Capture blocks
  ////////////////////////////////////////////////////////////////////////////

  trace_insn_capture u_insn_capture (
    .clk                   (clk),
    .rst_ni                (rst_ni),
    .instr_new_i           (instr_new_i),
    .instr_ret_i           (instr_ret_i),
    .instr_rdata_i         (instr_rdata_i),
    .instr_rdata_c_i       (instr_rdata_c_i),
    .instr_is_compressed_i (instr_is_compressed_i),
    .rs1_data_i            (rs1_data_i),
    .rs2_data_i            (rs2_data_i),
    .insn_open_o           (insn_open),
    .insn_o                (insn_word),
    .rs1_data_o            (rs1_data),
    .rs2_data_o            (rs2_data)
  );

  trace_rd_capture u_rd_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .insn_open_i (insn_open),
    .rd_we_i     (rd_we_i),
    .rd_addr_i   (rd_addr_i),
    .rd_wdata_i  (rd_wdata_i),
    .rd_addr_o   (rd_addr),
    .rd_wdata_o  (rd_wdata)
  );

  trace_mem_capture u_mem_capture (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .insn_open_i      (insn_open),
    .lsu_data_valid_i (lsu_data_valid_i),
    .data_type_i      (data_type_i),
    .data_we_i        (data_we_i),
    .mem_addr_i       (mem_addr_i),
    .mem_rdata_i      (mem_rdata_i),
    .mem_wdata_i      (mem_wdata_i),
    .mem_addr_o       (mem_addr),
    .mem_rdata_o      (mem_rdata),
    .mem_wdata_o      (mem_wdata),
    .mem_rmask_o      (mem_rmask),
    .mem_wmask_o      (mem_wmask)
  );

  trace_trap_tracker u_trap_tracker (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .insn_open_i  (insn_open),
    .instr_ret_i  (instr_ret_i),
    .pc_set_i     (pc_set_i),
    .pc_mux_i     (pc_mux_i),
    .exc_pc_mux_i (exc_pc_mux_i),
    .intr_o       (intr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Record register stage
  ////////////////////////////////////////////////////////////////////////////

  // Valid trails instr_ret_i by one cycle and the record is read with it
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o     <= 1'b0;
      rvfi_order_o     <= '0;
      rvfi_insn_o      <= '0;
      rvfi_trap_o      <= 1'b0;
      rvfi_intr_o      <= 1'b0;
      rvfi_mode_o      <= PRIV_M;
      rvfi_rs1_addr_o  <= '0;
      rvfi_rs2_addr_o  <= '0;
      rvfi_rs1_rdata_o <= '0;
      rvfi_rs2_rdata_o <= '0;
      rvfi_rd_addr_o   <= '0;
      rvfi_rd_wdata_o  <= '0;
      rvfi_pc_rdata_o  <= '0;
      rvfi_pc_wdata_o  <= '0;
      rvfi_mem_addr_o  <= '0;
      rvfi_mem_rmask_o <= '0;
      rvfi_mem_wmask_o <= '0;
      rvfi_mem_rdata_o <= '0;
      rvfi_mem_wdata_o <= '0;
    end else begin
      rvfi_valid_o     <= instr_ret_i;
      // Count advances after each emitted record
      rvfi_order_o     <= rvfi_order_o + ORDER_W'(rvfi_valid_o);
      rvfi_insn_o      <= insn_word;
      rvfi_trap_o      <= illegal_insn_i;
      rvfi_intr_o      <= intr;
      rvfi_mode_o      <= priv_mode_i;
      rvfi_rs1_addr_o  <= rs1_addr_i;
      rvfi_rs2_addr_o  <= rs2_addr_i;
      rvfi_rs1_rdata_o <= rs1_data;
      rvfi_rs2_rdata_o <= rs2_data;
      rvfi_rd_addr_o   <= rd_addr;
      rvfi_rd_wdata_o  <= rd_wdata;
      rvfi_pc_rdata_o  <= pc_id_i;
      rvfi_pc_wdata_o  <= pc_if_i;
      rvfi_mem_addr_o  <= mem_addr;
      rvfi_mem_rmask_o <= mem_rmask;
      rvfi_mem_wmask_o <= mem_wmask;
      rvfi_mem_rdata_o <= mem_rdata;
      rvfi_mem_wdata_o <= mem_wdata;
    end
  end

endmodule

// File: tests/trace_checker.sv
/*
 * Record checker for the trace unit. Models the capture rules from the
 * pipeline inputs and compares each record while rvfi_valid_o is high.
 */
module trace_checker (
  input logic                             clk,
  input logic                             rst_ni,
  input logic [trace_pkg::XLEN-1:0]       pc_id_i,
  input logic [trace_pkg::XLEN-1:0]       pc_if_i,
  input logic                             instr_new_i,
  input logic                             instr_ret_i,
  input logic                             illegal_insn_i,
  input logic [trace_pkg::XLEN-1:0]       instr_rdata_i,
  input logic [trace_pkg::INSN_C_W-1:0]   instr_rdata_c_i,
  input logic                             instr_is_compressed_i,
  input logic [trace_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input logic [trace_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  input logic [trace_pkg::XLEN-1:0]       rs1_data_i,
  input logic [trace_pkg::XLEN-1:0]       rs2_data_i,
  input logic [trace_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input logic [trace_pkg::XLEN-1:0]       rd_wdata_i,
  input logic                             rd_we_i,
  input logic                             lsu_data_valid_i,
  input logic [trace_pkg::XLEN-1:0]       mem_addr_i,
  input logic [trace_pkg::XLEN-1:0]       mem_rdata_i,
  input logic [trace_pkg::XLEN-1:0]       mem_wdata_i,
  input logic [trace_pkg::DTYPE_W-1:0]    data_type_i,
  input logic                             data_we_i,
  input logic                             pc_set_i,
  input logic [trace_pkg::PC_MUX_W-1:0]   pc_mux_i,
  input logic [trace_pkg::EXC_MUX_W-1:0]  exc_pc_mux_i,
  input logic [trace_pkg::PRIV_W-1:0]     priv_mode_i,
  input logic                             rvfi_valid_o,
  input logic [trace_pkg::ORDER_W-1:0]    rvfi_order_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_insn_o,
  input logic                             rvfi_trap_o,
  input logic                             rvfi_intr_o,
  input logic [trace_pkg::PRIV_W-1:0]     rvfi_mode_o,
  input logic [trace_pkg::REG_ADDR_W-1:0] rvfi_rs1_addr_o,
  input logic [trace_pkg::REG_ADDR_W-1:0] rvfi_rs2_addr_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_rs1_rdata_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_rs2_rdata_o,
  input logic [trace_pkg::REG_ADDR_W-1:0] rvfi_rd_addr_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_rd_wdata_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_pc_rdata_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_pc_wdata_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_mem_addr_o,
  input logic [trace_pkg::MASK_W-1:0]     rvfi_mem_rmask_o,
  input logic [trace_pkg::MASK_W-1:0]     rvfi_mem_wmask_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_mem_rdata_o,
  input logic [trace_pkg::XLEN-1:0]       rvfi_mem_wdata_o
);

  import trace_pkg::*;

  int                    records;
  int                    errors;
  int                    rec_errs;
  // Model state
  logic                  open_q, trap_q, open_now, e_valid;
  logic [XLEN-1:0]       rs1_q, rs2_q, rdd_q, ma_q, mr_q, mw_q;
  logic [REG_ADDR_W-1:0] rda_q;
  logic [MASK_W-1:0]     mask;
  // Predicted record
  logic [XLEN-1:0]       e_insn, e_rs1d, e_rs2d, e_rdd, e_pcr, e_pcw, e_ma, e_mr, e_mw;
  logic [REG_ADDR_W-1:0] e_rs1a, e_rs2a, e_rda;
  logic [MASK_W-1:0]     e_rm, e_wm;
  logic [PRIV_W-1:0]     e_mode;
  logic                  e_trap, e_intr;

  initial begin
    records = 0;
    errors  = 0;
  end

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
      rec_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Prediction from the pipeline inputs
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      {open_q, trap_q, e_valid} = '0;
      {rs1_q, rs2_q, rdd_q, rda_q, ma_q, mr_q, mw_q} = '0;
    end else begin
      open_now = instr_new_i | open_q;
      if (instr_new_i) begin
        rs1_q = rs1_data_i;
        rs2_q = rs2_data_i;
      end
      if (open_now) begin
        rda_q = rd_we_i ? rd_addr_i : '0;
        rdd_q = (rd_we_i && rd_addr_i != 0) ? rd_wdata_i : '0;
      end
      if (open_now && lsu_data_valid_i) begin
        ma_q = mem_addr_i;
        mr_q = mem_rdata_i;
        mw_q = mem_wdata_i;
      end
      case (data_type_i)
        DTYPE_WORD: mask = 4'b1111;
        DTYPE_HALF: mask = 4'b0011;
        DTYPE_BYTE: mask = 4'b0001;
        default:    mask = 4'b0000;
      endcase
      e_valid = instr_ret_i;
      if (instr_ret_i) begin
        e_insn = instr_is_compressed_i ? {16'h0, instr_rdata_c_i} : instr_rdata_i;
        e_rs1a = rs1_addr_i;
        e_rs2a = rs2_addr_i;
        e_rs1d = rs1_q;
        e_rs2d = rs2_q;
        e_rda  = rda_q;
        e_rdd  = rdd_q;
        e_pcr  = pc_id_i;
        e_pcw  = pc_if_i;
        e_ma   = ma_q;
        e_mr   = mr_q;
        e_mw   = mw_q;
        e_rm   = mask;
        e_wm   = data_we_i ? mask : 4'b0000;
        e_trap = illegal_insn_i;
        e_intr = trap_q & open_now;
        e_mode = priv_mode_i;
      end
      if (pc_set_i && pc_mux_i == 3'd2 && (exc_pc_mux_i == 2'd0 || exc_pc_mux_i == 2'd1)) begin
        trap_q = 1'b1;
      end else if (trap_q && instr_ret_i) begin
        trap_q = 1'b0;
      end
      open_q = instr_ret_i ? 1'b0 : open_now;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparison on the falling clock edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    rec_errs = 0;
    if (!rst_ni) begin
      check_field("rvfi_valid_o", 64'(rvfi_valid_o), 64'd0);
      check_field("rvfi_mode_o", 64'(rvfi_mode_o), 64'(PRIV_M));
      check_field("rvfi_order_o", rvfi_order_o, 64'd0);
    end else if (rvfi_valid_o !== e_valid) begin
      $display("At %0t the record valid strobe came at the wrong cycle", $time);
      errors++;
    end else if (rvfi_valid_o) begin
      check_field("rvfi_order_o", rvfi_order_o, 64'(records));
      check_field("rvfi_insn_o", 64'(rvfi_insn_o), 64'(e_insn));
      check_field("rvfi_trap_o", 64'(rvfi_trap_o), 64'(e_trap));
      check_field("rvfi_intr_o", 64'(rvfi_intr_o), 64'(e_intr));
      check_field("rvfi_mode_o", 64'(rvfi_mode_o), 64'(e_mode));
      check_field("rvfi_rs1_addr_o", 64'(rvfi_rs1_addr_o), 64'(e_rs1a));
      check_field("rvfi_rs2_addr_o", 64'(rvfi_rs2_addr_o), 64'(e_rs2a));
      check_field("rvfi_rs1_rdata_o", 64'(rvfi_rs1_rdata_o), 64'(e_rs1d));
      check_field("rvfi_rs2_rdata_o", 64'(rvfi_rs2_rdata_o), 64'(e_rs2d));
      check_field("rvfi_rd_addr_o", 64'(rvfi_rd_addr_o), 64'(e_rda));
      check_field("rvfi_rd_wdata_o", 64'(rvfi_rd_wdata_o), 64'(e_rdd));
      check_field("rvfi_pc_rdata_o", 64'(rvfi_pc_rdata_o), 64'(e_pcr));
      check_field("rvfi_pc_wdata_o", 64'(rvfi_pc_wdata_o), 64'(e_pcw));
      check_field("rvfi_mem_addr_o", 64'(rvfi_mem_addr_o), 64'(e_ma));
      check_field("rvfi_mem_rmask_o", 64'(rvfi_mem_rmask_o), 64'(e_rm));
      check_field("rvfi_mem_wmask_o", 64'(rvfi_mem_wmask_o), 64'(e_wm));
      check_field("rvfi_mem_rdata_o", 64'(rvfi_mem_rdata_o), 64'(e_mr));
      check_field("rvfi_mem_wdata_o", 64'(rvfi_mem_wdata_o), 64'(e_mw));
      $display("record %0d: %s", records, (rec_errs == 0) ? "ok" : "FAIL");
      records++;
    end
  end

endmodule

// File: tests/tb_retire_tracer.sv
/*
 * Testbench top for the retirement trace unit. Plays a table of
 * instructions into the pipeline ports, one row at a time, while
 * trace_checker predicts and compares every retired record.
 */
module tb_retire_tracer;

  import trace_pkg::*;

  localparam int ROWS       = 15;
  localparam int KIND_ALU   = 0;
  localparam int KIND_LOAD  = 1;
  localparam int KIND_STORE = 2;
  localparam int KIND_ILL   = 3;
  localparam int KIND_TRAP  = 4;

  logic                  clk = 1'b0;
  logic                  rst_ni;
  logic [XLEN-1:0]       pc_id_i, pc_if_i;
  logic                  instr_new_i, instr_ret_i, illegal_insn_i;
  logic [XLEN-1:0]       instr_rdata_i;
  logic [INSN_C_W-1:0]   instr_rdata_c_i;
  logic                  instr_is_compressed_i;
  logic [REG_ADDR_W-1:0] rs1_addr_i, rs2_addr_i, rd_addr_i;
  logic [XLEN-1:0]       rs1_data_i, rs2_data_i, rd_wdata_i;
  logic                  rd_we_i, lsu_data_valid_i, data_we_i, pc_set_i;
  logic [XLEN-1:0]       mem_addr_i, mem_rdata_i, mem_wdata_i;
  logic [DTYPE_W-1:0]    data_type_i;
  logic [PC_MUX_W-1:0]   pc_mux_i;
  logic [EXC_MUX_W-1:0]  exc_pc_mux_i;
  logic [PRIV_W-1:0]     priv_mode_i;
  logic                  rvfi_valid_o, rvfi_trap_o, rvfi_intr_o;
  logic [ORDER_W-1:0]    rvfi_order_o;
  logic [XLEN-1:0]       rvfi_insn_o, rvfi_rs1_rdata_o, rvfi_rs2_rdata_o, rvfi_rd_wdata_o;
  logic [PRIV_W-1:0]     rvfi_mode_o;
  logic [REG_ADDR_W-1:0] rvfi_rs1_addr_o, rvfi_rs2_addr_o, rvfi_rd_addr_o;
  logic [XLEN-1:0]       rvfi_pc_rdata_o, rvfi_pc_wdata_o, rvfi_mem_addr_o;
  logic [MASK_W-1:0]     rvfi_mem_rmask_o, rvfi_mem_wmask_o;
  logic [XLEN-1:0]       rvfi_mem_rdata_o, rvfi_mem_wdata_o;

  // Stimulus table, one entry per instruction
  logic [XLEN-1:0]       tbl_insn  [ROWS];
  logic                  tbl_comp  [ROWS];
  int                    tbl_kind  [ROWS];
  logic [DTYPE_W-1:0]    tbl_dtype [ROWS];
  logic                  tbl_we    [ROWS];
  logic [REG_ADDR_W-1:0] tbl_rs1   [ROWS];
  logic [REG_ADDR_W-1:0] tbl_rs2   [ROWS];
  logic [REG_ADDR_W-1:0] tbl_rd    [ROWS];
  int                    rows_added;
  integer                seed;
  logic [XLEN-1:0]       pc;

  retire_tracer dut0 (.*);

  trace_checker chk0 (.*);

  always #50 clk = ~clk;

  task automatic add_row(input logic [XLEN-1:0] insn, input logic comp, input int kind,
                         input logic [DTYPE_W-1:0] dtype, input logic we,
                         input logic [REG_ADDR_W-1:0] rs1, input logic [REG_ADDR_W-1:0] rs2,
                         input logic [REG_ADDR_W-1:0] rd);
    tbl_insn[rows_added]  = insn;
    tbl_comp[rows_added]  = comp;
    tbl_kind[rows_added]  = kind;
    tbl_dtype[rows_added] = dtype;
    tbl_we[rows_added]    = we;
    tbl_rs1[rows_added]   = rs1;
    tbl_rs2[rows_added]   = rs2;
    tbl_rd[rows_added]    = rd;
    rows_added++;
  endtask

  // Inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic play_row(input int i);
    if (tbl_kind[i] == KIND_TRAP) begin
      pc_set_i     = 1'b1;
      pc_mux_i     = PC_SEL_EXC;
      exc_pc_mux_i = (i % 2 == 0) ? EXC_PC_EXC : EXC_PC_IRQ;
      next_cycle();
      pc_set_i     = 1'b0;
      pc_mux_i     = '0;
    end
    instr_rdata_i         = tbl_insn[i];
    instr_rdata_c_i       = tbl_insn[i][INSN_C_W-1:0];
    instr_is_compressed_i = tbl_comp[i];
    rs1_addr_i            = tbl_rs1[i];
    rs2_addr_i            = tbl_rs2[i];
    rs1_data_i            = $random(seed);
    rs2_data_i            = $random(seed);
    rd_addr_i             = tbl_rd[i];
    rd_we_i               = tbl_we[i];
    rd_wdata_i            = $random(seed);
    pc_id_i               = pc;
    pc_if_i               = pc + (tbl_comp[i] ? 32'd2 : 32'd4);
    illegal_insn_i        = (tbl_kind[i] == KIND_ILL);
    data_type_i           = tbl_dtype[i];
    data_we_i             = (tbl_kind[i] == KIND_STORE);
    priv_mode_i           = (i % 2 == 0) ? PRIV_M : 2'd0;
    instr_new_i           = 1'b1;
    next_cycle();
    instr_new_i = 1'b0;
    // Register file moves on after decode
    rs1_data_i  = $random(seed);
    rs2_data_i  = $random(seed);
    if (tbl_kind[i] == KIND_LOAD || tbl_kind[i] == KIND_STORE) begin
      lsu_data_valid_i = 1'b1;
      mem_addr_i       = $random(seed);
      mem_rdata_i      = $random(seed);
      mem_wdata_i      = $random(seed);
      next_cycle();
      lsu_data_valid_i = 1'b0;
    end
    mem_addr_i  = $random(seed);
    mem_rdata_i = $random(seed);
    mem_wdata_i = $random(seed);
    instr_ret_i = 1'b1;
    next_cycle();
    instr_ret_i = 1'b0;
    pc          = pc_if_i;
    next_cycle();
  endtask

  initial begin
    seed = 42542;
    rows_added = 0;
    pc = 32'h0000_1000;
    {pc_id_i, pc_if_i, instr_new_i, instr_ret_i, illegal_insn_i} = '0;
    {instr_rdata_i, instr_rdata_c_i, instr_is_compressed_i} = '0;
    {rs1_addr_i, rs2_addr_i, rd_addr_i, rs1_data_i, rs2_data_i, rd_wdata_i, rd_we_i} = '0;
    {lsu_data_valid_i, mem_addr_i, mem_rdata_i, mem_wdata_i, data_type_i, data_we_i} = '0;
    {pc_set_i, pc_mux_i, exc_pc_mux_i} = '0;
    priv_mode_i = PRIV_M;
    rst_ni = 1'b0;

    add_row(32'h00b5_0533, 1'b0, KIND_ALU,   DTYPE_WORD, 1'b1, 5'd10, 5'd11, 5'd10);
    add_row(32'h0020_8033, 1'b0, KIND_ALU,   DTYPE_WORD, 1'b1, 5'd1,  5'd2,  5'd0);
    add_row(32'h0000_0063, 1'b0, KIND_ALU,   DTYPE_WORD, 1'b0, 5'd3,  5'd4,  5'd7);
    add_row(32'h0005_2583, 1'b0, KIND_LOAD,  DTYPE_WORD, 1'b1, 5'd10, 5'd0,  5'd11);
    add_row(32'h0005_1583, 1'b0, KIND_LOAD,  DTYPE_HALF, 1'b1, 5'd10, 5'd0,  5'd11);
    add_row(32'h0005_0583, 1'b0, KIND_LOAD,  DTYPE_BYTE, 1'b1, 5'd10, 5'd0,  5'd11);
    add_row(32'h00b5_2023, 1'b0, KIND_STORE, DTYPE_WORD, 1'b0, 5'd10, 5'd11, 5'd0);
    add_row(32'h00b5_1023, 1'b0, KIND_STORE, DTYPE_HALF, 1'b0, 5'd10, 5'd11, 5'd0);
    add_row(32'h00b5_0023, 1'b0, KIND_STORE, DTYPE_BYTE, 1'b0, 5'd10, 5'd11, 5'd0);
    // Upper half is junk and must not show in the record
    add_row(32'hdead_952e, 1'b1, KIND_ALU,   DTYPE_WORD, 1'b1, 5'd10, 5'd11, 5'd10);
    add_row(32'hbeef_4188, 1'b1, KIND_LOAD,  DTYPE_BYTE, 1'b1, 5'd11, 5'd0,  5'd10);
    add_row(32'hffff_ffff, 1'b0, KIND_ILL,   DTYPE_WORD, 1'b0, 5'd31, 5'd31, 5'd31);
    // Exception entry on an even row, interrupt entry on an odd row
    add_row(32'h3420_2573, 1'b0, KIND_TRAP,  DTYPE_WORD, 1'b1, 5'd0,  5'd0,  5'd10);
    add_row(32'h3410_25f3, 1'b0, KIND_TRAP,  DTYPE_WORD, 1'b1, 5'd0,  5'd0,  5'd11);
    add_row(32'h0015_0513, 1'b0, KIND_ALU,   DTYPE_WORD, 1'b1, 5'd10, 5'd0,  5'd10);

    repeat (3) @(posedge clk);
    #5;
    rst_ni = 1'b1;
    next_cycle();
    for (int i = 0; i < ROWS; i++) begin
      play_row(i);
    end
    repeat (2) next_cycle();

    $display("%0d records checked, %0d errors", chk0.records, chk0.errors);
    if (chk0.errors == 0 && chk0.records == ROWS) begin
      $display("Test passed");
    end else begin
      if (chk0.records != ROWS) begin
        $display("Expected %0d records but saw %0d", ROWS, chk0.records);
      end
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog allows five cycles per row plus a margin
  initial begin
    #((ROWS * 5 + 20) * 100);
    $display("Timeout: the stimulus did not finish in time");
    $display("Test failed");
    $finish;
  end

endmodule

// File: tb.f
hw/trace_pkg.sv
hw/trace_insn_capture.sv
hw/trace_rd_capture.sv
hw/trace_mem_capture.sv
hw/trace_trap_tracker.sv
hw/retire_tracer.sv
tests/trace_checker.sv
tests/tb_retire_tracer.sv

// File: Makefile
# Verilator build and run for the retirement trace unit

VERILATOR ?= verilator
TOP       ?= tb_retire_tracer
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Exit status follows the search for the pass message
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf $(BUILD_DIR)
